// File: compile.f
hw/matmul_pkg.sv
hw/mac_if.sv
hw/tdp_ram.sv
hw/tile_sequencer.sv
hw/dot_engine.sv
hw/matmul_top.sv
verification/matmul_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the matmul testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module matmul_tb -f compile.f -o matmul_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/matmul_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

// File: verification/matmul_tb.sv
/* Table-driven testbench for matmul_top with a reference model in the testbench.
   Checks exact tile timing, so it assumes the fixed latency of the design */
`timescale 1ns/1ps
`default_nettype none

module matmul_tb import matmul_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 1;  // Inputs change just after the rising edge
    localparam int NUM_TESTS  = 6;
    localparam int TIMEOUT_CYCLES =
        NUM_TESTS * (NUM_TILES * WORDS_PER_DOT + A_DEPTH + B_DEPTH + 20);

    // Pattern kinds
    localparam int KIND_KEEP  = 0; // Leave memory as loaded by the previous test
    localparam int KIND_RAND  = 1;
    localparam int KIND_EXT   = 2; // Random mixed with -128 and 127
    localparam int KIND_IDENT = 3; // Identity scaled by 1 << FRAC_B

    logic                clk;
    logic                rst_n;
    logic                start;
    logic                a_we;
    logic [A_ADDR_W-1:0] a_addr;
    a_word_t             a_din;
    logic                b_we;
    logic [B_ADDR_W-1:0] b_addr;
    b_word_t             b_din;
    logic                out_valid;
    logic                done;
    c_row_t              c_row0;
    c_row_t              c_row1;

    int seed = 88816;
    int row_errors = 0;
    int flag_errors = 0;
    int cycle_count = 0;

    // Test table
    string test_name [NUM_TESTS] = '{"identity_b", "random", "extremes",
                                     "busy_inject", "new_b_random", "new_b_identity"};
    int    a_kind    [NUM_TESTS] = '{KIND_RAND, KIND_RAND, KIND_EXT,
                                     KIND_RAND, KIND_KEEP, KIND_KEEP};
    int    b_kind    [NUM_TESTS] = '{KIND_IDENT, KIND_RAND, KIND_EXT,
                                     KIND_RAND, KIND_RAND, KIND_IDENT};
    bit    inject    [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    // Matrices as the testbench believes they sit in memory
    a_elem_t a_mat [ROWS_A][INNER_DIM];
    b_elem_t b_mat [INNER_DIM][COLS_B];

    matmul_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .a_we      (a_we),
        .a_addr    (a_addr),
        .a_din     (a_din),
        .b_we      (b_we),
        .b_addr    (b_addr),
        .b_din     (b_din),
        .out_valid (out_valid),
        .done      (done),
        .c_row0    (c_row0),
        .c_row1    (c_row1)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_row(input string test, input c_row_t exp, input c_row_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected=%h actual=%h", test, exp, act);
            row_errors++;
        end
    endtask

    task automatic check_flag(input string test, input string what, input logic exp,
                              input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s %s expected=%b actual=%b", test, what, exp, act);
            flag_errors++;
        end
    endtask

    function automatic int gen_value(input int kind, input int i, input int j);
        int v;
        v = $random(seed);
        case (kind)
            KIND_IDENT: return (i == j) ? (1 << FRAC_B) : 0;
            KIND_EXT:   return v[1] ? (v[0] ? 127 : -128) : v; // Half extremes
            default:    return v; // Low bits kept by the caller
        endcase
    endfunction

    // Exact sum, arithmetic shift, low WIDTH_OUT bits
    function automatic c_elem_t ref_elem(input int r, input int c);
        longint sum;
        sum = 0;
        for (int k = 0; k < INNER_DIM; k++) begin
            sum += longint'(a_mat[r][k]) * longint'(b_mat[k][c]);
        end
        return c_elem_t'(sum >>> FRAC_B);
    endfunction

    task automatic put_a_word(input int addr, input a_word_t word);
        a_we   = 1'b1;
        a_addr = A_ADDR_W'(addr);
        a_din  = word;
        @(posedge clk);
        #DRIVE_DLY;
        a_we = 1'b0;
    endtask

    task automatic put_b_word(input int addr, input b_word_t word);
        b_we   = 1'b1;
        b_addr = B_ADDR_W'(addr);
        b_din  = word;
        @(posedge clk);
        #DRIVE_DLY;
        b_we = 1'b0;
    endtask

    task automatic load_matrices(input int idx);
        a_word_t aw;
        b_word_t bw;
        if (a_kind[idx] != KIND_KEEP) begin
            for (int r = 0; r < ROWS_A; r++) begin
                for (int k = 0; k < INNER_DIM; k++) begin
                    a_mat[r][k] = a_elem_t'(gen_value(a_kind[idx], r, k));
                end
                for (int w = 0; w < WORDS_PER_DOT; w++) begin
                    for (int i = 0; i < CHUNK; i++) begin
                        aw[i] = a_mat[r][w * CHUNK + i]; // Element 0 low
                    end
                    put_a_word(r * WORDS_PER_DOT + w, aw);
                end
            end
        end
        if (b_kind[idx] != KIND_KEEP) begin
            for (int k = 0; k < INNER_DIM; k++) begin
                for (int c = 0; c < COLS_B; c++) begin
                    b_mat[k][c] = b_elem_t'(gen_value(b_kind[idx], k, c));
                end
            end
            for (int g = 0; g < COL_GROUPS; g++) begin
                for (int w = 0; w < WORDS_PER_DOT; w++) begin
                    for (int c = 0; c < COLS_PER_WORD; c++) begin
                        for (int i = 0; i < CHUNK; i++) begin
                            bw[c][i] = b_mat[w * CHUNK + i][g * COLS_PER_WORD + c];
                        end
                    end
                    put_b_word(g * WORDS_PER_DOT + w, bw);
                end
            end
        end
    endtask

    // Garbage start and writes that a busy design must ignore
    task automatic drive_inject(input bit on);
        start = on;
        a_we  = on;
        b_we  = on;
        if (on) begin
            a_addr = A_ADDR_W'($random(seed));
            a_din  = a_word_t'($random(seed));
            b_addr = B_ADDR_W'($random(seed));
            b_din  = b_word_t'({$random(seed), $random(seed)});
        end
    endtask

    task automatic run_and_check(input int idx);
        int      first_n;
        int      last_n;
        int      tile;
        int      rp;
        int      g;
        logic    pulse;
        c_row_t  exp0;
        c_row_t  exp1;
        first_n = WORDS_PER_DOT + 2; // Cycles from the start edge to tile 0
        last_n  = first_n + (NUM_TILES - 1) * WORDS_PER_DOT;
        check_flag(test_name[idx], "done before start", (idx > 0), done);
        start = 1'b1;
        @(posedge clk); // Start-sampling edge
        #DRIVE_DLY;
        start = 1'b0;
        for (int n = 0; n <= last_n + 3; n++) begin
            @(negedge clk); // Mid-cycle, outputs settled
            pulse = (n >= first_n) && (n <= last_n) && ((n - first_n) % WORDS_PER_DOT == 0);
            check_flag(test_name[idx], $sformatf("out_valid cycle %0d", n), pulse, out_valid);
            check_flag(test_name[idx], $sformatf("done cycle %0d", n), (n >= last_n), done);
            if (pulse) begin
                tile = (n - first_n) / WORDS_PER_DOT;
                rp   = tile / COL_GROUPS; // Row pair major
                g    = tile % COL_GROUPS;
                for (int c = 0; c < COLS_PER_WORD; c++) begin
                    exp0[c] = ref_elem(2 * rp, g * COLS_PER_WORD + c);
                    exp1[c] = ref_elem(2 * rp + 1, g * COLS_PER_WORD + c);
                end
                check_row($sformatf("%s tile %0d row0", test_name[idx], tile), exp0, c_row0);
                check_row($sformatf("%s tile %0d row1", test_name[idx], tile), exp1, c_row1);
            end
            @(posedge clk);
            #DRIVE_DLY;
            drive_inject(inject[idx] && (n < 4)); // Well inside the busy window
        end
    endtask

    initial begin
        rst_n  = 1'b0;
        start  = 1'b0;
        a_we   = 1'b0;
        a_addr = '0;
        a_din  = '0;
        b_we   = 1'b0;
        b_addr = '0;
        b_din  = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        check_flag("reset", "out_valid", 1'b0, out_valid);
        check_flag("reset", "done", 1'b0, done);

        for (int idx = 0; idx < NUM_TESTS; idx++) begin
            load_matrices(idx);
            run_and_check(idx);
        end

        $display("Error counts: row %0d, flag %0d", row_errors, flag_errors);
        if (row_errors + flag_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/matmul_top.sv
/* Block matmul top, C = A x B. Load both RAMs while idle, then strobe start;
   writes and start are ignored while busy and tiles are not held */
`timescale 1ns/1ps
`default_nettype none

module matmul_top import matmul_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire logic                a_we,
    input  wire logic [A_ADDR_W-1:0] a_addr, // row*WORDS_PER_DOT + k
    input  wire a_word_t             a_din,
    input  wire logic                b_we,
    input  wire logic [B_ADDR_W-1:0] b_addr, // group*WORDS_PER_DOT + k
    input  wire b_word_t             b_din,
    output logic                     out_valid,
    output logic                     done,
    output c_row_t                   c_row0, // Even row of the tile
    output c_row_t                   c_row1  // Odd row of the tile
);

    logic                busy;
    logic [A_ADDR_W-1:0] a_rd_addr0;
    logic [A_ADDR_W-1:0] a_rd_addr1;
    logic [B_ADDR_W-1:0] b_rd_addr;
    a_word_t             a_dout0;
    a_word_t             a_dout1;
    b_word_t             b_dout;

    mac_if mac_bus ();

    // Both ports read A, one row each
    tdp_ram #(
        .DATA_W ($bits(a_word_t)),
        .DEPTH  (A_DEPTH)
    ) a_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .busy      (busy),
        .we        (a_we),
        .wr_addr   (a_addr),
        .din       (a_din),
        .rd_addr_a (a_rd_addr0),
        .rd_addr_b (a_rd_addr1),
        .dout_a    (a_dout0),
        .dout_b    (a_dout1)
    );

    // B needs only port A for reads
    tdp_ram #(
        .DATA_W ($bits(b_word_t)),
        .DEPTH  (B_DEPTH)
    ) b_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .busy      (busy),
        .we        (b_we),
        .wr_addr   (b_addr),
        .din       (b_din),
        .rd_addr_a (b_rd_addr),
        .rd_addr_b ('0),
        .dout_a    (b_dout),
        .dout_b    ()
    );

    tile_sequencer seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .a_dout0    (a_dout0),
        .a_dout1    (a_dout1),
        .b_dout     (b_dout),
        .busy       (busy),
        .a_rd_addr0 (a_rd_addr0),
        .a_rd_addr1 (a_rd_addr1),
        .b_rd_addr  (b_rd_addr),
        .done       (done),
        .mac        (mac_bus.seq)
    );

    dot_engine engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .mac       (mac_bus.eng),
        .out_valid (out_valid),
        .c_row0    (c_row0),
        .c_row1    (c_row1)
    );

endmodule

`default_nettype wire

// File: hw/dot_engine.sv
/* 2 x COLS_PER_WORD MAC lanes, CHUNK products per beat. Results are shifted
   right by FRAC_B and truncated to WIDTH_OUT; tile outputs last one cycle */
`timescale 1ns/1ps
`default_nettype none

module dot_engine import matmul_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    mac_if.eng        mac,
    output logic      out_valid,
    output c_row_t    c_row0,
    output c_row_t    c_row1
);

    logic signed [ACC_WIDTH-1:0] beat_sum [2][COLS_PER_WORD]; // This beat's partial dot
    logic signed [ACC_WIDTH-1:0] acc [2][COLS_PER_WORD];      // Running sums per lane
    a_word_t                     a_rows [2];
    logic                        last_q; // Tile sums complete in acc

    // Exact signed slice dot product
    function automatic logic signed [ACC_WIDTH-1:0] chunk_dot(a_word_t a, b_col_t b);
        logic signed [ACC_WIDTH-1:0] s;
        s = '0;
        for (int i = 0; i < CHUNK; i++) begin
            s = s + $signed(a[i]) * $signed(b[i]); // Extended to ACC_WIDTH first
        end
        return s;
    endfunction

    assign a_rows[0] = mac.a_row0;
    assign a_rows[1] = mac.a_row1;

    always_comb begin
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < COLS_PER_WORD; c++) begin
                beat_sum[r][c] = chunk_dot(a_rows[r], mac.b_word[c]);
            end
        end
    end

    // Tile strobe, one cycle behind the closing beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            last_q    <= mac.beat_valid && mac.last;
            out_valid <= last_q;
        end
    end

    // Accumulate and capture
    always_ff @(posedge clk) begin
        if (mac.beat_valid) begin
            for (int r = 0; r < 2; r++) begin
                for (int c = 0; c < COLS_PER_WORD; c++) begin
                    if (mac.first) begin
                        acc[r][c] <= beat_sum[r][c]; // Drops the previous tile
                    end else begin
                        acc[r][c] <= acc[r][c] + beat_sum[r][c];
                    end
                end
            end
        end
        // Next tile may load acc on this same edge
        if (last_q) begin
            for (int c = 0; c < COLS_PER_WORD; c++) begin
                c_row0[c] <= WIDTH_OUT'(acc[0][c] >>> FRAC_B); // Arithmetic shift
                c_row1[c] <= WIDTH_OUT'(acc[1][c] >>> FRAC_B);
            end
        end
    end

    // Tile markers from the sequencer never arrive outside a beat
    a_marker_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        (mac.first || mac.last || mac.tile_last) |-> mac.beat_valid
    ) else $error("dot_engine tile marker without beat_valid");

endmodule

`default_nettype wire

// File: hw/tile_sequencer.sv
/* Run control for one C = A x B pass. start is accepted only while idle;
   tiles go row pair major, column group minor, k-word innermost */
`timescale 1ns/1ps
`default_nettype none

module tile_sequencer import matmul_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire a_word_t             a_dout0,
    input  wire a_word_t             a_dout1,
    input  wire b_word_t             b_dout,
    output logic                     busy,
    output logic      [A_ADDR_W-1:0] a_rd_addr0,
    output logic      [A_ADDR_W-1:0] a_rd_addr1,
    output logic      [B_ADDR_W-1:0] b_rd_addr,
    output logic                     done,
    mac_if.seq                       mac
);

    // Counter widths, at least one bit each
    localparam int K_W = (WORDS_PER_DOT > 1) ? $clog2(WORDS_PER_DOT) : 1;
    localparam int C_W = (COL_GROUPS > 1) ? $clog2(COL_GROUPS) : 1;
    localparam int R_W = (ROW_PAIRS > 1) ? $clog2(ROW_PAIRS) : 1;

    logic [K_W-1:0] k_cnt;   // k-word within the dot product
    logic [C_W-1:0] col_cnt; // Column group
    logic [R_W-1:0] row_cnt; // Row pair
    logic           draining;    // Final read in flight
    logic           tile_last_q; // Final beat seen by the engine
    logic           issue;
    logic           accept;
    logic           k_max;
    logic           col_max;
    logic           row_max;
    logic           final_addr;

    assign accept     = start && !busy; // Strobe ignored mid-run
    assign issue      = busy && !draining;
    assign k_max      = (k_cnt == K_W'(WORDS_PER_DOT - 1));
    assign col_max    = (col_cnt == C_W'(COL_GROUPS - 1));
    assign row_max    = (row_cnt == R_W'(ROW_PAIRS - 1));
    assign final_addr = k_max && col_max && row_max;

    // Even row, odd row, and B group addresses
    assign a_rd_addr0 = A_ADDR_W'((2 * int'(row_cnt)) * WORDS_PER_DOT + int'(k_cnt));
    assign a_rd_addr1 = A_ADDR_W'((2 * int'(row_cnt) + 1) * WORDS_PER_DOT + int'(k_cnt));
    assign b_rd_addr  = B_ADDR_W'(int'(col_cnt) * WORDS_PER_DOT + int'(k_cnt));

    // RAM outputs are already one cycle behind the addresses
    assign mac.a_row0 = a_dout0;
    assign mac.a_row1 = a_dout1;
    assign mac.b_word = b_dout;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy           <= 1'b0;
            draining       <= 1'b0;
            k_cnt          <= '0;
            col_cnt        <= '0;
            row_cnt        <= '0;
            done           <= 1'b0;
            tile_last_q    <= 1'b0;
            mac.beat_valid <= 1'b0;
            mac.first      <= 1'b0;
            mac.last       <= 1'b0;
            mac.tile_last  <= 1'b0;
        end else begin
            tile_last_q <= mac.beat_valid && mac.tile_last; // Engine output lands next edge

            if (accept) begin
                busy     <= 1'b1;
                draining <= 1'b0;
                k_cnt    <= '0;
                col_cnt  <= '0;
                row_cnt  <= '0;
                done     <= 1'b0; // Cleared by the new run
            end else begin
                if (tile_last_q) begin
                    done <= 1'b1; // Same edge as the final out_valid
                end
                if (draining) begin
                    busy     <= 1'b0; // One cycle after the final beat
                    draining <= 1'b0;
                end
            end

            // Control bits delayed to line up with RAM data
            mac.beat_valid <= issue;
            mac.first      <= issue && (k_cnt == '0);
            mac.last       <= issue && k_max;
            mac.tile_last  <= issue && final_addr;

            if (issue) begin
                if (k_max) begin
                    k_cnt <= '0;
                    if (col_max) begin
                        col_cnt <= '0;
                        row_cnt <= row_max ? '0 : row_cnt + 1'b1;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end else begin
                    k_cnt <= k_cnt + 1'b1;
                end
                if (final_addr) begin
                    draining <= 1'b1; // Counters wrap back to tile 0
                end
            end
        end
    end

    // Full-width addresses from the counters stay inside both memories
    a_addr_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        busy |-> ((2 * int'(row_cnt) + 1) * WORDS_PER_DOT + int'(k_cnt) < A_DEPTH)
                 && (int'(col_cnt) * WORDS_PER_DOT + int'(k_cnt) < B_DEPTH)
    ) else $error("tile_sequencer address out of range");

endmodule

`default_nettype wire

// File: hw/tdp_ram.sv
/* Behavioral dual-port RAM with one-cycle read latency. Port A writes only
   while idle; busy switches port A to the read address. Read-old-data on write */
`timescale 1ns/1ps
`default_nettype none

module tdp_ram #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 8
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     busy,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] wr_addr,
    input  wire logic [DATA_W-1:0]        din,
    input  wire logic [$clog2(DEPTH)-1:0] rd_addr_a,
    input  wire logic [$clog2(DEPTH)-1:0] rd_addr_b,
    output logic      [DATA_W-1:0]        dout_a,
    output logic      [DATA_W-1:0]        dout_b
);

    localparam int AW = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [AW-1:0]     addr_a; // Shared write/read address of port A
    logic              wr_en;

    assign addr_a = busy ? rd_addr_a : wr_addr; // Controller owns port A in compute
    assign wr_en  = we && !busy;                // External writes only while idle

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr_a] <= din;
        end
    end

    // Registered read ports
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_a <= '0;
            dout_b <= '0;
        end else begin
            dout_a <= mem[addr_a]; // Old contents on a write cycle
            dout_b <= mem[rd_addr_b];
        end
    end

    // A write attempted during compute leaves the addressed word untouched
    a_no_write_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        busy |=> (mem[$past(wr_addr)] == $past(mem[wr_addr]))
    ) else $error("tdp_ram word changed while busy");

endmodule

`default_nettype wire

// File: hw/mac_if.sv
/* Operand beat from the sequencer to the MAC engine. No back-pressure,
   a beat is valid for exactly one cycle */
`timescale 1ns/1ps
`default_nettype none

interface mac_if import matmul_pkg::*; ();

    logic    beat_valid; // RAM data on this cycle is a real beat
    logic    first;      // Restart accumulators with this beat
    logic    last;       // Closing beat of a tile
    logic    tile_last;  // Closing beat of the last tile of the run
    a_word_t a_row0;     // Even row slice
    a_word_t a_row1;     // Odd row slice
    b_word_t b_word;     // COLS_PER_WORD column slices

    // Sequencer side
    modport seq (
        output beat_valid, first, last, tile_last,
        output a_row0, a_row1, b_word
    );

    // Engine side
    modport eng (
        input beat_valid, first, last, tile_last,
        input a_row0, a_row1, b_word
    );

endinterface

`default_nettype wire

// File: hw/matmul_pkg.sv
/* Fixed-point matmul constants and word types. Dimensions are fixed here
   and INNER_DIM must be a multiple of CHUNK, ROWS_A even, COLS_B a multiple of COLS_PER_WORD */
`default_nettype none

package matmul_pkg;

    // Element formats, signed two's complement
    localparam int WIDTH_A   = 8;
    localparam int FRAC_A    = 4;  // C keeps this many fractional bits
    localparam int WIDTH_B   = 8;
    localparam int FRAC_B    = 4;  // Also the output shift
    localparam int WIDTH_OUT = 16;
    localparam int ACC_WIDTH = 20; // Holds any INNER_DIM-term sum exactly

    // Matrix shape
    localparam int CHUNK         = 4; // Elements per row/column slice in one word
    localparam int INNER_DIM     = 8;
    localparam int ROWS_A        = 4;
    localparam int COLS_B        = 4;
    localparam int COLS_PER_WORD = 2;

    // Derived tiling
    localparam int WORDS_PER_DOT = INNER_DIM / CHUNK;    // Beats per tile
    localparam int ROW_PAIRS     = ROWS_A / 2;
    localparam int COL_GROUPS    = COLS_B / COLS_PER_WORD;
    localparam int NUM_TILES     = ROW_PAIRS * COL_GROUPS;

    // Memory geometry
    localparam int A_DEPTH  = ROWS_A * WORDS_PER_DOT;     // Addr = row*WPD + k
    localparam int B_DEPTH  = COL_GROUPS * WORDS_PER_DOT; // Addr = group*WPD + k
    localparam int A_ADDR_W = $clog2(A_DEPTH);
    localparam int B_ADDR_W = $clog2(B_DEPTH);

    typedef logic signed [WIDTH_A-1:0]   a_elem_t;
    typedef logic signed [WIDTH_B-1:0]   b_elem_t;
    typedef logic signed [WIDTH_OUT-1:0] c_elem_t;

    // Element 0 in the low bits
    typedef a_elem_t [CHUNK-1:0] a_word_t;
    typedef b_elem_t [CHUNK-1:0] b_col_t;

    // Column 0 of the group in the low half
    typedef b_col_t [COLS_PER_WORD-1:0] b_word_t;

    typedef c_elem_t [COLS_PER_WORD-1:0] c_row_t;

endpackage

`default_nettype wire
